//--- design/dispatch_pkg.sv
package dispatch_pkg;

    localparam int XLEN      = 32;
    localparam int NUM_SLOTS = 2;     // dual issue
    localparam int NUM_SRC   = 2;     // source operands per instruction

    typedef logic [XLEN-1:0] word_t;      // data, pc or instruction word
    typedef logic [4:0]      reg_addr_t;  // x0 is hard-wired zero
    typedef logic [7:0]      alu_op_t;
    typedef logic [2:0]      alu_sel_t;

    // function class of memory instructions
    localparam alu_sel_t ALU_SEL_LOAD_STORE = 3'b111;

    localparam alu_op_t ALU_PCADDU12I = 8'h0e;  // pc-relative upper imm add

    // opcodes treated as loads by the load-use check
    localparam alu_op_t ALU_LDB  = 8'h20;
    localparam alu_op_t ALU_LDH  = 8'h21;
    localparam alu_op_t ALU_LDW  = 8'h22;
    localparam alu_op_t ALU_LDBU = 8'h23;
    localparam alu_op_t ALU_LDHU = 8'h24;
    localparam alu_op_t ALU_LLW  = 8'h25;
    localparam alu_op_t ALU_SCW  = 8'h26;   // sc.w returns a value, so it counts too

    // one decoded instruction from the decode stage
    typedef struct packed {
        logic                    valid;
        word_t                   pc;
        word_t                   inst;
        logic [NUM_SRC-1:0]      rd_en;         // one bit per source
        reg_addr_t [NUM_SRC-1:0] rd_addr;
        logic                    wr_en;
        reg_addr_t               wr_addr;
        word_t                   imm;
        alu_op_t                 alu_op;
        alu_sel_t                alu_sel;
        logic                    is_privilege;  // only steers dual issue
        logic                    is_cnt;        // only steers dual issue
    } dec_slot_t;

    // one bypass writer of a later stage
    typedef struct packed {
        logic      wr_en;
        reg_addr_t wr_addr;
        word_t     wr_data;
    } fwd_port_t;

    // one issued instruction as seen by execute
    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     inst;
        alu_op_t   alu_op;
        alu_sel_t  alu_sel;
        logic      wr_en;
        reg_addr_t wr_addr;
        word_t     src1;
        word_t     src2;
    } iss_slot_t;

    // register file read data of one slot, index is the source number
    typedef struct packed {
        word_t [NUM_SRC-1:0] data;
    } rf_pair_t;

endpackage

//--- design/dispatch_ctrl.sv
`timescale 1ns/1ps

module dispatch_ctrl (
    input  dispatch_pkg::dec_slot_t [dispatch_pkg::NUM_SLOTS-1:0] slot_i,
    input  dispatch_pkg::fwd_port_t [dispatch_pkg::NUM_SLOTS-1:0] ex_fwd_i,
    input  dispatch_pkg::alu_op_t   [dispatch_pkg::NUM_SLOTS-1:0] ex_alu_op_i,
    input  logic                                                  pause_i,
    input  logic                                                  flush_i,
    input  logic                                                  ex_pause_i,
    output logic [dispatch_pkg::NUM_SLOTS-1:0]                    issue_en,
    output logic [dispatch_pkg::NUM_SLOTS-1:0]                    grant_o,
    output logic                                                  load_use_stall_o,
    output logic                                                  clear_en,
    output logic                                                  hold_en
);
    import dispatch_pkg::*;

    logic [NUM_SLOTS-1:0] slot_valid;
    logic                 mem_inst;     // any memory-class slot
    logic                 cnt_inst;     // any counter read
    logic                 priv_inst;    // any privileged slot
    logic                 raw_hazard;   // slot 1 needs slot 0 result
    logic                 dual_ok;
    logic                 ex_load;      // load sitting in execute
    logic [NUM_SLOTS-1:0] load_dep;     // per slot dependency on that load

    function automatic logic is_load(input alu_op_t op);
        case (op)
            ALU_LDB, ALU_LDH, ALU_LDW,
            ALU_LDBU, ALU_LDHU,
            ALU_LLW, ALU_SCW: is_load = 1'b1;
            default:          is_load = 1'b0;
        endcase
    endfunction

    // conditions that force single issue
    always_comb begin
        mem_inst  = 1'b0;
        cnt_inst  = 1'b0;
        priv_inst = 1'b0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            slot_valid[i] = slot_i[i].valid;
            mem_inst      = mem_inst  | (slot_i[i].alu_sel == ALU_SEL_LOAD_STORE);
            cnt_inst      = cnt_inst  | slot_i[i].is_cnt;
            priv_inst     = priv_inst | slot_i[i].is_privilege;
        end
    end

    // read-after-write inside the bundle
    always_comb begin
        raw_hazard = 1'b0;
        for (int s = 0; s < NUM_SRC; s++) begin
            if (slot_i[1].rd_en[s] && (slot_i[1].rd_addr[s] == slot_i[0].wr_addr)) begin
                raw_hazard = 1'b1;
            end
        end
        raw_hazard = raw_hazard && slot_i[0].wr_en && (slot_i[0].wr_addr != '0);
    end

    assign dual_ok = (&slot_valid) && !mem_inst && !cnt_inst && !priv_inst && !raw_hazard;

    // older slot goes first when the pair cannot issue together
    always_comb begin
        if (dual_ok) begin
            issue_en = 2'b11;
        end else if (slot_valid[0]) begin
            issue_en = 2'b01;
        end else if (slot_valid[1]) begin
            issue_en = 2'b10;
        end else begin
            issue_en = 2'b00;
        end
    end

    assign grant_o = pause_i ? '0 : issue_en;  // decode keeps its slots while paused

    assign ex_load = is_load(ex_alu_op_i[0]) || is_load(ex_alu_op_i[1]);

    // loads only issue alone, so writer 0 carries the load destination
    always_comb begin
        load_dep = '0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            for (int s = 0; s < NUM_SRC; s++) begin
                if (slot_i[i].rd_en[s] && (slot_i[i].rd_addr[s] == ex_fwd_i[0].wr_addr)) begin
                    load_dep[i] = 1'b1;
                end
            end
        end
    end

    assign load_use_stall_o = ex_load && (|load_dep);

    // a bubble goes to execute unless execute itself is stalled
    assign clear_en = flush_i || (load_use_stall_o && !ex_pause_i);
    assign hold_en  = pause_i && !clear_en;

endmodule

//--- design/operand_forward.sv
`timescale 1ns/1ps

module operand_forward (
    input  dispatch_pkg::dec_slot_t                               slot_i,
    input  dispatch_pkg::rf_pair_t                                rf_i,
    input  dispatch_pkg::fwd_port_t [dispatch_pkg::NUM_SLOTS-1:0] ex_fwd_i,
    input  dispatch_pkg::fwd_port_t [dispatch_pkg::NUM_SLOTS-1:0] mem_fwd_i,
    input  dispatch_pkg::fwd_port_t [dispatch_pkg::NUM_SLOTS-1:0] wb_fwd_i,
    output dispatch_pkg::word_t                                   src1_o,
    output dispatch_pkg::word_t                                   src2_o
);
    import dispatch_pkg::*;

    word_t [NUM_SRC-1:0] base_val;   // rf data or immediate
    word_t [NUM_SRC-1:0] wb_val;     // after write-back bypass
    word_t [NUM_SRC-1:0] mem_val;    // after memory bypass
    word_t [NUM_SRC-1:0] ex_val;     // after execute bypass
    word_t [NUM_SRC-1:0] src;        // final operand
    logic                is_pcadd;

    // one stage of bypass, writer 0 beats writer 1
    function automatic word_t stage_pick(
        input fwd_port_t [NUM_SLOTS-1:0] fwd,
        input logic                      rd_en,
        input reg_addr_t                 rd_addr,
        input word_t                     lower
    );
        word_t res;
        res = lower;
        for (int w = NUM_SLOTS - 1; w >= 0; w--) begin
            if (fwd[w].wr_en && rd_en && (fwd[w].wr_addr == rd_addr)) begin
                res = fwd[w].wr_data;
            end
        end
        return res;
    endfunction

    always_comb begin
        for (int s = 0; s < NUM_SRC; s++) begin
            base_val[s] = slot_i.rd_en[s] ? rf_i.data[s] : slot_i.imm;
        end
    end

    // oldest stage first so younger results override it
    always_comb begin
        for (int s = 0; s < NUM_SRC; s++) begin
            wb_val[s] = stage_pick(wb_fwd_i, slot_i.rd_en[s], slot_i.rd_addr[s], base_val[s]);
        end
    end

    always_comb begin
        for (int s = 0; s < NUM_SRC; s++) begin
            mem_val[s] = stage_pick(mem_fwd_i, slot_i.rd_en[s], slot_i.rd_addr[s], wb_val[s]);
        end
    end

    always_comb begin
        for (int s = 0; s < NUM_SRC; s++) begin
            ex_val[s] = stage_pick(ex_fwd_i, slot_i.rd_en[s], slot_i.rd_addr[s], mem_val[s]);
        end
    end

    assign is_pcadd = (slot_i.alu_op == ALU_PCADDU12I);

    // x0 and pcaddu12i override any bypass hit
    always_comb begin
        for (int s = 0; s < NUM_SRC; s++) begin
            src[s] = ex_val[s];
            if (slot_i.rd_en[s] && (slot_i.rd_addr[s] == '0)) begin
                src[s] = '0;
            end
            if (slot_i.rd_en[s] && is_pcadd) begin
                src[s] = slot_i.pc;          // adder takes pc in place of rj
            end
        end
    end

    assign src1_o = src[0];
    assign src2_o = src[1];

endmodule

//--- design/issue_reg.sv
`timescale 1ns/1ps

module issue_reg (
    input  logic                                                    clk,
    input  logic                                                    rst_n_i,
    input  dispatch_pkg::dec_slot_t [dispatch_pkg::NUM_SLOTS-1:0]   slot_i,
    input  dispatch_pkg::word_t
           [dispatch_pkg::NUM_SLOTS*dispatch_pkg::NUM_SRC-1:0]      src_i,
    input  logic [dispatch_pkg::NUM_SLOTS-1:0]                      issue_en,
    input  logic                                                    clear_en,
    input  logic                                                    hold_en,
    output dispatch_pkg::iss_slot_t [dispatch_pkg::NUM_SLOTS-1:0]   iss_slot_o
);
    import dispatch_pkg::*;

    iss_slot_t [NUM_SLOTS-1:0] iss_nxt;

    // ungranted slots become all-zero bubbles
    always_comb begin
        iss_nxt = '0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (issue_en[i]) begin
                iss_nxt[i].valid   = slot_i[i].valid;
                iss_nxt[i].pc      = slot_i[i].pc;
                iss_nxt[i].inst    = slot_i[i].inst;
                iss_nxt[i].alu_op  = slot_i[i].alu_op;
                iss_nxt[i].alu_sel = slot_i[i].alu_sel;
                iss_nxt[i].wr_en   = slot_i[i].wr_en;
                iss_nxt[i].wr_addr = slot_i[i].wr_addr;
                iss_nxt[i].src1    = src_i[i*NUM_SRC];
                iss_nxt[i].src2    = src_i[i*NUM_SRC+1];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            iss_slot_o <= '0;
        end else if (clear_en) begin
            iss_slot_o <= '0;                // flush or load-use bubble
        end else if (!hold_en) begin
            iss_slot_o <= iss_nxt;
        end
    end

endmodule

//--- design/dispatch.sv
`timescale 1ns/1ps

module dispatch (
    input  logic                                                  clk,
    input  logic                                                  rst_n_i,

    // decoded bundle and its register file reads
    input  dispatch_pkg::dec_slot_t [dispatch_pkg::NUM_SLOTS-1:0] slot_i,
    input  dispatch_pkg::rf_pair_t  [dispatch_pkg::NUM_SLOTS-1:0] rf_data_i,

    // bypass from later stages
    input  dispatch_pkg::fwd_port_t [dispatch_pkg::NUM_SLOTS-1:0] ex_fwd_i,
    input  dispatch_pkg::fwd_port_t [dispatch_pkg::NUM_SLOTS-1:0] mem_fwd_i,
    input  dispatch_pkg::fwd_port_t [dispatch_pkg::NUM_SLOTS-1:0] wb_fwd_i,
    input  dispatch_pkg::alu_op_t   [dispatch_pkg::NUM_SLOTS-1:0] ex_alu_op_i,

    input  logic                                                  pause_i,
    input  logic                                                  flush_i,
    input  logic                                                  ex_pause_i,

    output logic [dispatch_pkg::NUM_SLOTS-1:0]                    issue_grant_o,
    output logic                                                  load_use_stall_o,
    output dispatch_pkg::iss_slot_t [dispatch_pkg::NUM_SLOTS-1:0] iss_slot_o
);
    import dispatch_pkg::*;

    logic [NUM_SLOTS-1:0]          issue_en;
    logic                          clear_en;
    logic                          hold_en;
    word_t [NUM_SLOTS*NUM_SRC-1:0] src;       // slot-major operand words

    dispatch_ctrl u_ctrl (
        .slot_i           (slot_i),
        .ex_fwd_i         (ex_fwd_i),
        .ex_alu_op_i      (ex_alu_op_i),
        .pause_i          (pause_i),
        .flush_i          (flush_i),
        .ex_pause_i       (ex_pause_i),
        .issue_en         (issue_en),
        .grant_o          (issue_grant_o),
        .load_use_stall_o (load_use_stall_o),
        .clear_en         (clear_en),
        .hold_en          (hold_en)
    );

    operand_forward u_fwd0 (
        .slot_i    (slot_i[0]),
        .rf_i      (rf_data_i[0]),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .wb_fwd_i  (wb_fwd_i),
        .src1_o    (src[0]),
        .src2_o    (src[1])
    );

    operand_forward u_fwd1 (
        .slot_i    (slot_i[1]),
        .rf_i      (rf_data_i[1]),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .wb_fwd_i  (wb_fwd_i),
        .src1_o    (src[2]),
        .src2_o    (src[3])
    );

    issue_reg u_issue_reg (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .slot_i     (slot_i),
        .src_i      (src),
        .issue_en   (issue_en),
        .clear_en   (clear_en),
        .hold_en    (hold_en),
        .iss_slot_o (iss_slot_o)
    );

endmodule

//--- bench/dispatch_tasks.svh
task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
endtask

task automatic check_iss();
    for (int i = 0; i < NUM_SLOTS; i++) begin
        checks++;
        if (iss_slot[i] !== exp_iss[i]) begin
            errors++;
            $display("** Error at %0t: iss_slot_o[%0d] got %h expected %h",
                     $time, i, iss_slot[i], exp_iss[i]);
        end
    end
endtask

// entered 10 ns after an edge, leaves 10 ns after the next one
task automatic run_cycle(input logic [1:0] want_grant, input logic want_stall);
    logic [NUM_SLOTS-1:0] en;
    en = expected_issue_en();
    #40;
    check_val("issue_grant_o", issue_grant, want_grant);
    check_val("load_use_stall_o", load_use_stall, want_stall);
    if (flush || (want_stall && !ex_pause)) begin
        exp_iss = '0;
    end else if (!pause) begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            exp_iss[i] = expected_issue(i, en[i]);
        end
    end
    @(posedge clk);
    #5;
    check_iss();
    #5;
endtask

task automatic clear_inputs();
    slot      = '0;
    rf_data   = '0;
    ex_fwd    = '0;
    mem_fwd   = '0;
    wb_fwd    = '0;
    ex_alu_op = '0;
    pause     = 1'b0;
    flush     = 1'b0;
    ex_pause  = 1'b0;
endtask

// plain two-source alu instruction, random words
task automatic set_alu_slot(input int i, input reg_addr_t rd, input reg_addr_t rs1,
                            input reg_addr_t rs2);
    slot[i]            = '0;
    slot[i].valid      = 1'b1;
    slot[i].pc         = $urandom() & 32'hffff_fffc;
    slot[i].inst       = $urandom();
    slot[i].rd_en      = 2'b11;
    slot[i].rd_addr[0] = rs1;
    slot[i].rd_addr[1] = rs2;
    slot[i].wr_en      = 1'b1;
    slot[i].wr_addr    = rd;
    slot[i].imm        = $urandom();
    slot[i].alu_op     = 8'h01;   // outside the load and pcaddu12i codes
    slot[i].alu_sel    = 3'b001;
    rf_data[i].data[0] = $urandom();
    rf_data[i].data[1] = $urandom();
endtask

task automatic set_pair();
    set_alu_slot(0, 5'd5, 5'd1, 5'd2);
    set_alu_slot(1, 5'd6, 5'd3, 5'd4);
endtask

task automatic set_writer(inout fwd_port_t p, input reg_addr_t addr);
    p.wr_en   = 1'b1;
    p.wr_addr = addr;
    p.wr_data = $urandom();
endtask

task automatic test_reset_and_issue();
    check_iss();                                            // both slots zero out of reset
    clear_inputs();
    set_pair();
    run_cycle(2'b11, 1'b0);
    set_pair();
    slot[1].alu_sel = ALU_SEL_LOAD_STORE;
    run_cycle(2'b01, 1'b0);
    set_pair();
    slot[1].is_cnt = 1'b1;
    run_cycle(2'b01, 1'b0);
    set_pair();
    slot[0].is_privilege = 1'b1;
    run_cycle(2'b01, 1'b0);
    set_pair();
    slot[1].rd_addr[1] = 5'd5;                              // reads slot 0 result
    run_cycle(2'b01, 1'b0);
    set_pair();
    slot[0].valid = 1'b0;
    run_cycle(2'b10, 1'b0);
endtask

task automatic test_base_operands();
    clear_inputs();
    set_pair();
    slot[0].rd_en      = 2'b01;                             // src2 takes imm
    slot[1].rd_addr[0] = 5'd0;
    set_writer(ex_fwd[0], 5'd0);
    run_cycle(2'b11, 1'b0);
    check_val("slot 0 src1 from rf", iss_slot[0].src1, rf_data[0].data[0]);
    check_val("slot 0 src2 from imm", iss_slot[0].src2, slot[0].imm);
    check_val("slot 1 x0 read", iss_slot[1].src1, 32'h0);
endtask

task automatic test_bypass_priority();
    clear_inputs();
    set_pair();
    slot[0].rd_addr[0] = 5'd9;
    set_writer(wb_fwd[0], 5'd9);
    run_cycle(2'b11, 1'b0);
    check_val("wb bypass", iss_slot[0].src1, wb_fwd[0].wr_data);
    set_writer(mem_fwd[1], 5'd9);
    run_cycle(2'b11, 1'b0);
    check_val("mem over wb", iss_slot[0].src1, mem_fwd[1].wr_data);
    set_writer(ex_fwd[1], 5'd9);
    run_cycle(2'b11, 1'b0);
    check_val("ex over mem", iss_slot[0].src1, ex_fwd[1].wr_data);
    set_writer(ex_fwd[0], 5'd9);
    run_cycle(2'b11, 1'b0);
    check_val("writer 0 over writer 1", iss_slot[0].src1, ex_fwd[0].wr_data);
endtask

task automatic test_pc_relative();
    clear_inputs();
    set_pair();
    slot[0].alu_op = ALU_PCADDU12I;
    set_writer(ex_fwd[0], 5'd1);                            // pc still wins
    run_cycle(2'b11, 1'b0);
    check_val("pcaddu12i src1", iss_slot[0].src1, slot[0].pc);
    check_val("pcaddu12i src2", iss_slot[0].src2, slot[0].pc);
endtask

task automatic test_load_use();
    clear_inputs();
    set_pair();
    ex_alu_op[0]      = ALU_LDW;
    ex_fwd[0].wr_addr = 5'd3;                               // enable left low
    run_cycle(2'b11, 1'b1);
    ex_pause = 1'b1;
    run_cycle(2'b11, 1'b1);
    ex_pause     = 1'b0;
    ex_alu_op[0] = 8'h01;
    ex_alu_op[1] = ALU_LDBU;
    run_cycle(2'b11, 1'b1);
    ex_alu_op[1] = 8'h01;
    run_cycle(2'b11, 1'b0);
endtask

task automatic test_pause_flush();
    clear_inputs();
    set_pair();
    run_cycle(2'b11, 1'b0);
    set_pair();
    pause = 1'b1;
    run_cycle(2'b00, 1'b0);
    pause = 1'b0;
    flush = 1'b1;
    run_cycle(2'b11, 1'b0);
    clear_inputs();
    run_cycle(2'b00, 1'b0);
endtask

//--- bench/tb_dispatch.sv
`timescale 1ns/1ps

module tb_dispatch;
    import dispatch_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int MAX_CYCLES = 50;    // about twice the directed sequence

    logic                      clk;
    logic                      rst_n_i;
    dec_slot_t [NUM_SLOTS-1:0] slot;
    rf_pair_t  [NUM_SLOTS-1:0] rf_data;
    fwd_port_t [NUM_SLOTS-1:0] ex_fwd;
    fwd_port_t [NUM_SLOTS-1:0] mem_fwd;
    fwd_port_t [NUM_SLOTS-1:0] wb_fwd;
    alu_op_t   [NUM_SLOTS-1:0] ex_alu_op;
    logic                      pause;
    logic                      flush;
    logic                      ex_pause;
    logic [NUM_SLOTS-1:0]      issue_grant;
    logic                      load_use_stall;
    iss_slot_t [NUM_SLOTS-1:0] iss_slot;

    iss_slot_t [NUM_SLOTS-1:0] exp_iss;   // model of the issue register
    int errors = 0;
    int checks = 0;
    int cycles = 0;

    dispatch u_dispatch (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .slot_i           (slot),
        .rf_data_i        (rf_data),
        .ex_fwd_i         (ex_fwd),
        .mem_fwd_i        (mem_fwd),
        .wb_fwd_i         (wb_fwd),
        .ex_alu_op_i      (ex_alu_op),
        .pause_i          (pause),
        .flush_i          (flush),
        .ex_pause_i       (ex_pause),
        .issue_grant_o    (issue_grant),
        .load_use_stall_o (load_use_stall),
        .iss_slot_o       (iss_slot)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD/2) clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // slots granted by the dual-issue rule, pause not applied
    function automatic logic [NUM_SLOTS-1:0] expected_issue_en();
        logic single_only;
        logic dep;
        single_only = 1'b0;
        dep         = 1'b0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (slot[i].alu_sel == ALU_SEL_LOAD_STORE || slot[i].is_cnt ||
                slot[i].is_privilege) begin
                single_only = 1'b1;
            end
        end
        for (int s = 0; s < NUM_SRC; s++) begin
            if (slot[0].wr_en && slot[0].wr_addr != 5'd0 && slot[1].rd_en[s] &&
                slot[1].rd_addr[s] == slot[0].wr_addr) begin
                dep = 1'b1;
            end
        end
        if (slot[0].valid && slot[1].valid && !single_only && !dep) begin
            return 2'b11;
        end
        if (slot[0].valid) begin
            return 2'b01;
        end
        if (slot[1].valid) begin
            return 2'b10;
        end
        return 2'b00;
    endfunction

    // highest priority first: pc, x0, then ex/mem/wb writers in order
    function automatic word_t expected_operand(input int i, input int s);
        reg_addr_t                   a;
        fwd_port_t [3*NUM_SLOTS-1:0] writers;
        a       = slot[i].rd_addr[s];
        writers = {wb_fwd, mem_fwd, ex_fwd};   // index 0 is ex writer 0
        if (!slot[i].rd_en[s]) begin
            return slot[i].imm;
        end
        if (slot[i].alu_op == ALU_PCADDU12I) begin
            return slot[i].pc;
        end
        if (a == 5'd0) begin
            return '0;
        end
        for (int w = 0; w < 3*NUM_SLOTS; w++) begin
            if (writers[w].wr_en && writers[w].wr_addr == a) begin
                return writers[w].wr_data;
            end
        end
        return rf_data[i].data[s];
    endfunction

    function automatic iss_slot_t expected_issue(input int i, input logic en);
        iss_slot_t r;
        r = '0;
        if (en) begin
            r.valid   = slot[i].valid;
            r.pc      = slot[i].pc;
            r.inst    = slot[i].inst;
            r.alu_op  = slot[i].alu_op;
            r.alu_sel = slot[i].alu_sel;
            r.wr_en   = slot[i].wr_en;
            r.wr_addr = slot[i].wr_addr;
            r.src1    = expected_operand(i, 0);
            r.src2    = expected_operand(i, 1);
        end
        return r;
    endfunction

    `include "dispatch_tasks.svh"

    initial begin
        void'($urandom(32'h50e));
        exp_iss = '0;
        rst_n_i = 1'b0;
        clear_inputs();
        repeat (5) @(posedge clk);
        #10;
        rst_n_i = 1'b1;
        test_reset_and_issue();
        test_base_operands();
        test_bypass_priority();
        test_pc_relative();
        test_load_use();
        test_pause_flush();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- dispatch.f
+incdir+bench
design/dispatch_pkg.sv
design/dispatch_ctrl.sv
design/operand_forward.sv
design/issue_reg.sv
design/dispatch.sv
bench/tb_dispatch.sv
